// File: design/eeprom_pkg.sv
package eeprom_pkg;

    // memory geometry of a 2 KB part
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // device type code, upper nibble of every control byte
    localparam logic [3:0] DEV_TAG = 4'b1010;

    // host operation, value doubles as the r/w bit
    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // byte level bus commands, sequencer to bit engine
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,   // start or repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,   // byte out, ack in
        CMD_READ  = 2'd3    // byte in, ack out
    } bus_cmd_e;

endpackage

// File: design/host_port.sv
`timescale 1ns/1ps
module host_port (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req,
    input  eeprom_pkg::op_e      op,
    input  eeprom_pkg::addr_t    addr,
    input  eeprom_pkg::data_t    wdata,
    output logic                 ack,
    output eeprom_pkg::data_t    rdata,
    output logic                 nack_err,
    output logic                 start,
    output eeprom_pkg::op_e      start_op,
    output eeprom_pkg::addr_t    start_addr,
    output eeprom_pkg::data_t    start_wdata,
    input  logic                 finish,
    input  eeprom_pkg::data_t    result_data,
    input  logic                 result_nack
);

    typedef enum logic [1:0]
    {
        HP_IDLE,
        HP_BUSY,
        HP_ACK
    } hp_state_e;

    hp_state_e state;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= HP_IDLE;
            ack      <= 1'b0;
            start    <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                HP_IDLE:
                begin
                    if (req)   // ack is already low here
                    begin
                        start <= 1'b1;
                        state <= HP_BUSY;
                    end
                end
                HP_BUSY:
                begin
                    if (finish)
                    begin
                        ack      <= 1'b1;
                        nack_err <= result_nack;
                        state    <= HP_ACK;
                    end
                end
                HP_ACK:
                begin
                    if (!req)   // host has seen ack
                    begin
                        ack   <= 1'b0;
                        state <= HP_IDLE;
                    end
                end
                default: state <= HP_IDLE;
            endcase
        end
    end

    // request and result registers
    always_ff @(posedge CLK)
    begin
        if (state == HP_IDLE && req)
        begin
            start_op    <= op;
            start_addr  <= addr;
            start_wdata <= wdata;
        end
        if (state == HP_BUSY && finish)
            rdata <= result_data;   // held while ack is high
    end

endmodule

// File: design/eeprom_sequencer.sv
`timescale 1ns/1ps
module eeprom_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      start,
    input  eeprom_pkg::op_e           start_op,
    input  eeprom_pkg::addr_t         start_addr,
    input  eeprom_pkg::data_t         start_wdata,
    output logic                      finish,
    output eeprom_pkg::data_t         result_data,
    output logic                      result_nack,
    output logic                      cmd_valid,
    output eeprom_pkg::bus_cmd_e      cmd,
    output eeprom_pkg::data_t         tx_byte,
    output logic                      tx_nack,
    input  logic                      cmd_done,
    input  eeprom_pkg::data_t         rx_byte,
    input  logic                      rx_nack
);

    // one-hot transaction states
    localparam logic [8:0] S_IDLE    = 9'b0_0000_0001;
    localparam logic [8:0] S_START   = 9'b0_0000_0010;
    localparam logic [8:0] S_CTRL_W  = 9'b0_0000_0100;
    localparam logic [8:0] S_ADDR    = 9'b0_0000_1000;
    localparam logic [8:0] S_DATA_W  = 9'b0_0001_0000;
    localparam logic [8:0] S_RESTART = 9'b0_0010_0000;
    localparam logic [8:0] S_CTRL_R  = 9'b0_0100_0000;
    localparam logic [8:0] S_DATA_R  = 9'b0_1000_0000;
    localparam logic [8:0] S_STOP    = 9'b1_0000_0000;

    logic [8:0]            state;
    logic                  issued;   // command of this state sent to the engine
    eeprom_pkg::bus_cmd_e  cmd_d;
    eeprom_pkg::data_t     byte_d;
    logic                  nack_d;
    logic [2:0]            page;

    assign page = start_addr[eeprom_pkg::ADDR_W-1:8];   // block select bits

    // command belonging to each state
    always_comb
    begin
        cmd_d  = eeprom_pkg::CMD_WRITE;
        byte_d = '0;
        nack_d = 1'b0;
        case (state)
            S_START, S_RESTART: cmd_d = eeprom_pkg::CMD_START;
            S_CTRL_W:  byte_d = {eeprom_pkg::DEV_TAG, page, 1'b0};
            S_ADDR:    byte_d = start_addr[7:0];
            S_DATA_W:  byte_d = start_wdata;
            S_CTRL_R:  byte_d = {eeprom_pkg::DEV_TAG, page, 1'b1};
            S_DATA_R:
            begin
                cmd_d  = eeprom_pkg::CMD_READ;
                nack_d = 1'b1;   // single byte, master ends with nack
            end
            S_STOP:    cmd_d = eeprom_pkg::CMD_STOP;
            default:   cmd_d = eeprom_pkg::CMD_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= S_IDLE;
            issued      <= 1'b0;
            cmd_valid   <= 1'b0;
            finish      <= 1'b0;
            result_nack <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            finish    <= 1'b0;
            if (state == S_IDLE)
            begin
                if (start)
                begin
                    result_nack <= 1'b0;
                    state       <= S_START;
                end
            end
            else if (!issued)
            begin
                cmd_valid <= 1'b1;
                issued    <= 1'b1;
            end
            else if (cmd_done)
            begin
                issued <= 1'b0;
                if (cmd == eeprom_pkg::CMD_WRITE && rx_nack)
                    result_nack <= 1'b1;
                case (state)
                    S_START:   state <= S_CTRL_W;
                    S_CTRL_W:  state <= rx_nack ? S_STOP : S_ADDR;
                    S_ADDR:
                    begin
                        if (rx_nack)
                            state <= S_STOP;
                        else if (start_op == eeprom_pkg::OP_READ)
                            state <= S_RESTART;
                        else
                            state <= S_DATA_W;
                    end
                    S_DATA_W:  state <= S_STOP;
                    S_RESTART: state <= S_CTRL_R;
                    S_CTRL_R:  state <= rx_nack ? S_STOP : S_DATA_R;
                    S_DATA_R:  state <= S_STOP;
                    S_STOP:
                    begin
                        finish <= 1'b1;
                        state  <= S_IDLE;
                    end
                    default:   state <= S_IDLE;
                endcase
            end
        end
    end

    // command payload and read result
    always_ff @(posedge CLK)
    begin
        if (state != S_IDLE && !issued)
        begin
            cmd     <= cmd_d;
            tx_byte <= byte_d;
            tx_nack <= nack_d;
        end
        if (state == S_DATA_R && issued && cmd_done)
            result_data <= rx_byte;
    end

endmodule

// File: design/i2c_bit_engine.sv
`timescale 1ns/1ps
module i2c_bit_engine #(
    parameter int CLK_DIV = 4   // clocks per quarter scl period
) (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      cmd_valid,
    input  eeprom_pkg::bus_cmd_e      cmd,
    input  eeprom_pkg::data_t         tx_byte,
    input  logic                      tx_nack,
    output logic                      cmd_done,
    output eeprom_pkg::data_t         rx_byte,
    output logic                      rx_nack,
    output logic                      scl,
    output logic                      sda_oe,
    input  logic                      sda_in
);

    localparam int QW = $clog2(CLK_DIV + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);

    logic                  busy;
    logic [QW-1:0]         qcnt;      // clocks within a quarter
    logic [1:0]            quarter;
    logic [3:0]            bcnt;      // bit within the command
    logic [3:0]            last_bit;
    logic                  bit_end;
    logic                  sample;
    logic                  is_byte;
    eeprom_pkg::bus_cmd_e  cmd_q;
    eeprom_pkg::data_t     tx_sh;
    logic                  tx_nack_q;
    logic                  scl_d;
    logic                  sda_oe_d;

    assign is_byte  = (cmd_q == eeprom_pkg::CMD_WRITE) || (cmd_q == eeprom_pkg::CMD_READ);
    assign last_bit = is_byte ? 4'd8 : 4'd0;
    assign bit_end  = busy && qcnt == Q_LAST && quarter == 2'd3;
    // bus lags the counters by one clock, so this is the last clock of quarter two
    assign sample   = busy && qcnt == '0 && quarter == 2'd2;

    // bus levels for the current quarter
    always_comb
    begin
        scl_d    = scl;
        sda_oe_d = sda_oe;
        if (busy)
        begin
            case (cmd_q)
                eeprom_pkg::CMD_START:
                begin
                    // scl held in the first quarter, so no spurious edge from idle
                    if (quarter != 2'd0)
                        scl_d = (quarter != 2'd3);
                    sda_oe_d = quarter[1];   // sda falls while scl high
                end
                eeprom_pkg::CMD_STOP:
                begin
                    scl_d    = (quarter != 2'd0);   // stays high into idle
                    sda_oe_d = !quarter[1];         // sda rises while scl high
                end
                eeprom_pkg::CMD_WRITE:
                begin
                    scl_d    = quarter == 2'd1 || quarter == 2'd2;
                    sda_oe_d = (bcnt == 4'd8) ? 1'b0 : !tx_sh[eeprom_pkg::DATA_W-1];
                end
                default:
                begin
                    scl_d    = quarter == 2'd1 || quarter == 2'd2;
                    sda_oe_d = (bcnt == 4'd8) ? !tx_nack_q : 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            cmd_done <= 1'b0;
            qcnt     <= '0;
            quarter  <= 2'd0;
            bcnt     <= 4'd0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            scl      <= scl_d;
            sda_oe   <= sda_oe_d;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy    <= 1'b1;
                    qcnt    <= '0;
                    quarter <= 2'd0;
                    bcnt    <= 4'd0;
                end
            end
            else if (qcnt == Q_LAST)
            begin
                qcnt    <= '0;
                quarter <= quarter + 2'd1;
                if (quarter == 2'd3)
                begin
                    if (bcnt == last_bit)
                    begin
                        busy     <= 1'b0;
                        cmd_done <= 1'b1;
                    end
                    else
                        bcnt <= bcnt + 4'd1;
                end
            end
            else
                qcnt <= qcnt + 1'b1;
        end
    end

    // shift registers
    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
        begin
            cmd_q     <= cmd;
            tx_sh     <= tx_byte;
            tx_nack_q <= tx_nack;
        end
        else if (bit_end)
            tx_sh <= {tx_sh[eeprom_pkg::DATA_W-2:0], 1'b0};   // msb first

        if (sample)
        begin
            if (bcnt == 4'd8)
                rx_nack <= sda_in;   // high means no ack
            else if (cmd_q == eeprom_pkg::CMD_READ)
                rx_byte <= {rx_byte[eeprom_pkg::DATA_W-2:0], sda_in};
        end
    end

endmodule

// File: design/eeprom_ctrl_top.sv
`timescale 1ns/1ps
module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req,
    input  eeprom_pkg::op_e      op,
    input  eeprom_pkg::addr_t    addr,
    input  eeprom_pkg::data_t    wdata,
    output logic                 ack,
    output eeprom_pkg::data_t    rdata,
    output logic                 nack_err,
    output logic                 scl,
    output logic                 sda_oe,   // pulls sda low when high
    input  logic                 sda_in
);

    logic                  start;
    eeprom_pkg::op_e       start_op;
    eeprom_pkg::addr_t     start_addr;
    eeprom_pkg::data_t     start_wdata;
    logic                  finish;
    eeprom_pkg::data_t     result_data;
    logic                  result_nack;

    logic                  cmd_valid;
    eeprom_pkg::bus_cmd_e  cmd;
    eeprom_pkg::data_t     tx_byte;
    logic                  tx_nack;
    logic                  cmd_done;
    eeprom_pkg::data_t     rx_byte;
    logic                  rx_nack;

    host_port host_port_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .nack_err    (nack_err),
        .start       (start),
        .start_op    (start_op),
        .start_addr  (start_addr),
        .start_wdata (start_wdata),
        .finish      (finish),
        .result_data (result_data),
        .result_nack (result_nack)
    );

    eeprom_sequencer eeprom_sequencer_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .start       (start),
        .start_op    (start_op),
        .start_addr  (start_addr),
        .start_wdata (start_wdata),
        .finish      (finish),
        .result_data (result_data),
        .result_nack (result_nack),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .tx_nack     (tx_nack),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .rx_nack     (rx_nack)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i2c_bit_engine_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_nack   (tx_nack),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_nack   (rx_nack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

// File: test/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic no_ack,      // withhold every ack
    output logic sda_pull     // open-drain pull-down
);

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  shift;
    logic [7:0]  tx;
    logic        scl_q;
    logic        sda_q;
    logic        active;      // taking part since the last start
    logic        reading;     // sending data to the master
    logic        ack_bit;     // inside the ninth clock of a byte
    int          bit_cnt;
    int          byte_cnt;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        ptr      = '0;
        sda_pull = 1'b0;
        active   = 1'b0;
        reading  = 1'b0;
        ack_bit  = 1'b0;
        bit_cnt  = 0;
        byte_cnt = 0;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
    end

    task take_byte();
        if (byte_cnt == 0 && shift[7:4] != eeprom_pkg::DEV_TAG)
            active = 1'b0;   // silent until the next start
        else
        begin
            sda_pull = !no_ack;   // byte still taken when the ack is withheld
            if (byte_cnt == 0)
            begin
                ptr[10:8] = shift[3:1];   // block bits from the control byte
                reading   = shift[0];
                tx        = mem[ptr];
            end
            else if (byte_cnt == 1)
                ptr[7:0] = shift;
            else
                mem[ptr] = shift;
            byte_cnt++;
        end
    endtask

    task clock_rise();
        if (active && !ack_bit)
        begin
            shift = {shift[6:0], sda};
            bit_cnt++;
        end
        else if (active && reading && !sda_pull)   // master answers a byte sent
        begin
            if (sda)
                active = 1'b0;   // master nack ends the read
            else
            begin
                ptr = ptr + 11'd1;
                tx  = mem[ptr];
            end
        end
    endtask

    task clock_fall();
        if (active && ack_bit)
        begin
            ack_bit  = 1'b0;
            bit_cnt  = 0;
            sda_pull = reading ? !tx[7] : 1'b0;
        end
        else if (active && bit_cnt == 8)
        begin
            ack_bit = 1'b1;
            if (reading)
                sda_pull = 1'b0;   // master answers now
            else
                take_byte();
        end
        else if (active && reading)
            sda_pull = !tx[7 - bit_cnt];
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl !== scl_q)
        begin
            if (scl === 1'b1)
                clock_rise();
            else
                clock_fall();
        end
        else if (scl === 1'b1 && sda !== sda_q)
        begin
            active   = (sda === 1'b0);   // start opens, stop closes
            reading  = 1'b0;
            ack_bit  = 1'b0;
            bit_cnt  = 0;
            byte_cnt = 0;
            sda_pull = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: test/eeprom_ctrl_sva.sv
`timescale 1ns/1ps
module eeprom_ctrl_sva (
    input logic CLK,
    input logic RESET,
    input logic req,
    input logic ack,
    input logic sda_oe
);

    ack_rise_with_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack) |-> $past(req))
        else $error("ack rose with no request pending");

    // four-phase return to zero
    ack_fall_after_req: assert property (@(posedge CLK) disable iff (RESET)
        $fell(ack) |-> $past(!req))
        else $error("ack fell while req was still high");

    bus_idle_on_ack: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> !sda_oe)
        else $error("sda pulled low while ack is high");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_sva eeprom_ctrl_sva_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .req    (req),
    .ack    (ack),
    .sda_oe (sda_oe)
);

// File: test/eeprom_ctrl_tb.sv
`timescale 1ns/1ps
module eeprom_ctrl_tb;

    localparam int CLK_DIV  = 2;
    localparam int N_RANDOM = 20;
    localparam int N_TRANS  = 50;   // transactions over all tests
    // a read is about 40 bit periods of four quarters each, doubled for margin
    localparam int WATCHDOG_NS = N_TRANS * 40 * 4 * CLK_DIV * 100 * 2;

    logic               CLK;
    logic               RESET;
    logic               req;
    eeprom_pkg::op_e    op;
    eeprom_pkg::addr_t  addr;
    eeprom_pkg::data_t  wdata;
    logic               ack;
    eeprom_pkg::data_t  rdata;
    logic               nack_err;
    logic               scl;
    logic               sda_oe;
    logic               sda;
    logic               sda_pull;
    logic               no_ack;

    eeprom_pkg::data_t  shadow [0:2047];   // last byte written per address
    int                 errors;
    int                 tests_ok;
    int                 tests_bad;

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) dut_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    eeprom_model model_i (
        .scl      (scl),
        .sda      (sda),
        .no_ack   (no_ack),
        .sda_pull (sda_pull)
    );

    assign sda = !(sda_oe || sda_pull);   // pulled up unless someone sinks it

    always #50 CLK = ~CLK;

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a transaction never completed", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_data(input string what, input eeprom_pkg::data_t got,
                              input eeprom_pkg::data_t exp);
        if (got !== exp)
        begin
            $display("Fail at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
        begin
            tests_ok++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("%s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    task automatic wait_ack(input logic level);
        do
            @(negedge CLK);
        while (ack !== level);
    endtask

    // full four-phase handshake
    task automatic transact(input eeprom_pkg::op_e t_op, input eeprom_pkg::addr_t t_addr,
                            input eeprom_pkg::data_t t_wdata,
                            output eeprom_pkg::data_t t_rdata, output logic t_nack);
        @(negedge CLK);
        op    = t_op;
        addr  = t_addr;
        wdata = t_wdata;
        req   = 1'b1;
        wait_ack(1'b1);
        t_rdata = rdata;
        t_nack  = nack_err;
        req     = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic write_byte(input eeprom_pkg::addr_t a, input eeprom_pkg::data_t d);
        eeprom_pkg::data_t rd;
        logic              nk;
        transact(eeprom_pkg::OP_WRITE, a, d, rd, nk);
        check_flag("write nack_err", nk, 1'b0);
        shadow[a] = d;
    endtask

    task automatic read_compare(input eeprom_pkg::addr_t a);
        eeprom_pkg::data_t rd;
        logic              nk;
        transact(eeprom_pkg::OP_READ, a, 8'h00, rd, nk);
        check_flag("read nack_err", nk, 1'b0);
        check_data($sformatf("read of %03h", a), rd, shadow[a]);
    endtask

    task automatic reset_state();
        int e0;
        e0 = errors;
        check_flag("ack after reset", ack, 1'b0);
        check_flag("scl after reset", scl, 1'b1);
        check_flag("sda_oe after reset", sda_oe, 1'b0);
        report_test("reset_state", e0);
    endtask

    task automatic write_then_read();
        int e0;
        e0 = errors;
        write_byte(11'h2a5, 8'h96);
        read_compare(11'h2a5);
        report_test("write_then_read", e0);
    endtask

    task automatic random_traffic();
        eeprom_pkg::addr_t list [N_RANDOM];
        eeprom_pkg::addr_t tmp;
        int unsigned       r;
        int                j;
        int                e0;
        e0 = errors;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r       = $urandom;
            list[i] = r[10:0];
            write_byte(list[i], r[31:24]);
        end
        for (int i = N_RANDOM - 1; i > 0; i--)   // shuffle the read order
        begin
            j       = $urandom_range(i, 0);
            tmp     = list[i];
            list[i] = list[j];
            list[j] = tmp;
        end
        for (int i = 0; i < N_RANDOM; i++)
            read_compare(list[i]);
        report_test("random_traffic", e0);
    endtask

    task automatic missing_ack();
        eeprom_pkg::addr_t a;
        eeprom_pkg::data_t rd;
        logic              nk;
        int unsigned       r;
        int                e0;
        e0 = errors;
        r  = $urandom;
        a  = r[10:0];
        write_byte(a, 8'hc3);
        @(negedge CLK);
        no_ack = 1'b1;
        transact(eeprom_pkg::OP_WRITE, a, 8'h3c, rd, nk);
        check_flag("nack_err on refused write", nk, 1'b1);
        transact(eeprom_pkg::OP_READ, a, 8'h00, rd, nk);
        check_flag("nack_err on refused read", nk, 1'b1);
        @(negedge CLK);
        no_ack = 1'b0;
        read_compare(a);   // refused write must not land
        report_test("missing_ack", e0);
    endtask

    task automatic handshake_hold();
        eeprom_pkg::addr_t a;
        eeprom_pkg::data_t rd;
        logic              nk;
        int unsigned       r;
        int                hold;
        int                e0;
        e0 = errors;
        r  = $urandom;
        a  = r[10:0];
        write_byte(a, r[18:11]);
        @(negedge CLK);
        op    = eeprom_pkg::OP_READ;
        addr  = a;
        wdata = 8'h00;
        req   = 1'b1;
        wait_ack(1'b1);
        rd = rdata;
        nk = nack_err;
        check_data("held read", rd, shadow[a]);
        check_flag("held read nack_err", nk, 1'b0);
        hold = $urandom_range(30, 5);
        repeat (hold)
        begin
            @(negedge CLK);
            check_flag("ack while req high", ack, 1'b1);
            check_data("rdata while ack high", rdata, rd);
            check_flag("nack_err while ack high", nack_err, nk);
        end
        req = 1'b0;
        @(negedge CLK);   // next request follows without waiting for ack low
        check_flag("ack before next request", ack, 1'b0);
        a     = a ^ 11'h7ff;
        op    = eeprom_pkg::OP_WRITE;
        addr  = a;
        wdata = ~rd;
        req   = 1'b1;
        wait_ack(1'b1);
        check_flag("second request nack_err", nack_err, 1'b0);
        req       = 1'b0;
        shadow[a] = ~rd;
        wait_ack(1'b0);
        read_compare(a);
        report_test("handshake_hold", e0);
    endtask

    initial
    begin
        CLK       = 1'b0;
        RESET     = 1'b1;
        req       = 1'b0;
        op        = eeprom_pkg::OP_WRITE;
        addr      = '0;
        wdata     = '0;
        no_ack    = 1'b0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        void'($urandom(58366));
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        reset_state();
        write_then_read();
        random_traffic();
        missing_ack();
        handshake_hold();
        $display("%0d tests ok, %0d tests with mismatches, %0d mismatches in all",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: files.f
design/eeprom_pkg.sv
design/host_port.sv
design/eeprom_sequencer.sv
design/i2c_bit_engine.sv
design/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/eeprom_ctrl_sva.sv
test/eeprom_ctrl_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module eeprom_ctrl_tb -o eeprom_ctrl_sim \
    && ./obj_dir/eeprom_ctrl_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
